// File: hdl/cache_pkg.sv
package cache_pkg;

  // address and data geometry.
  parameter int addr_w   = 32;
  parameter int data_w   = 64;
  parameter int index_w  = 5;  // 32 sets.
  parameter int offset_w = 6;  // 64 byte line.
  parameter int tag_w    = addr_w - index_w - offset_w;
  parameter int beat_w   = 3;
  parameter int beats    = 8;  // beats per line burst.

  // request size codes.
  parameter logic [1:0] size_b1 = 2'd0;
  parameter logic [1:0] size_b2 = 2'd1;
  parameter logic [1:0] size_b4 = 2'd2;
  parameter logic [1:0] size_b8 = 2'd3;

  typedef struct packed {
    logic [tag_w-1:0]             tag;
    logic [index_w-1:0]           index;
    logic [beat_w-1:0]            beat;
    logic [offset_w-beat_w-1:0]   byte_off;
  } cache_addr_fields_t;

  // one address word, seen raw or split into cache fields.
  typedef union packed {
    logic [addr_w-1:0]  raw;
    cache_addr_fields_t f;
  } cache_addr_t;

endpackage

// File: hdl/tag_store.sv
`timescale 1ns/1ps

module tag_store import cache_pkg::*; #(
  parameter int ways = 2,
  localparam int way_w = $clog2(ways)
) (
  input  logic               clk,
  input  logic               rst,
  input  cache_addr_t        lookup_addr_i,
  input  logic               set_dirty_i,
  input  logic               fill_i,
  input  logic [way_w-1:0]   fill_way_i,
  input  logic [index_w-1:0] fill_index_i,
  input  logic [tag_w-1:0]   fill_tag_i,
  input  logic               advance_victim_i,
  output logic               hit_o,
  output logic [way_w-1:0]   hit_way_o,
  output logic [way_w-1:0]   victim_way_o,
  output logic               victim_dirty_o,
  output logic [tag_w-1:0]   victim_tag_o
);

  localparam int sets = 1 << index_w;

  logic [tag_w-1:0]   tag_q [ways][sets];
  logic [sets-1:0]    valid_q [ways];
  logic [sets-1:0]    dirty_q [ways];
  logic [way_w-1:0]   victim_q;
  logic [ways-1:0]    match;
  logic [index_w-1:0] idx;

  assign idx = lookup_addr_i.f.index;

  for (genvar w = 0; w < ways; w++) begin : g_way
    assign match[w] = valid_q[w][idx] && (tag_q[w][idx] == lookup_addr_i.f.tag);
  end

  assign hit_o = |match;

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < ways; w++) begin
      if (match[w]) hit_way_o = hit_way_o | way_w'(w);  // match is one-hot.
    end
  end

  assign victim_way_o   = victim_q;
  assign victim_dirty_o = valid_q[victim_q][idx] && dirty_q[victim_q][idx];
  assign victim_tag_o   = tag_q[victim_q][idx];

  always_ff @(posedge clk) begin
    if (fill_i) tag_q[fill_way_i][fill_index_i] <= fill_tag_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= '{default: '0};
      dirty_q  <= '{default: '0};
      victim_q <= '0;
    end else begin
      if (fill_i) begin
        valid_q[fill_way_i][fill_index_i] <= 1'b1;
        dirty_q[fill_way_i][fill_index_i] <= 1'b0;
      end
      if (set_dirty_i) dirty_q[hit_way_o][idx] <= 1'b1;
      if (advance_victim_i) begin
        victim_q <= (victim_q == way_w'(ways - 1)) ? '0 : victim_q + 1'b1;
      end
    end
  end

  a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

// File: hdl/data_store.sv
`timescale 1ns/1ps

module data_store import cache_pkg::*; #(
  parameter int ways = 2,
  localparam int way_w = $clog2(ways)
) (
  input  logic                         clk,
  input  logic                         we_i,
  input  logic [way_w-1:0]             way_i,
  input  logic [index_w-1:0]           index_i,
  input  logic [beat_w-1:0]            beat_i,
  input  logic [offset_w-beat_w-1:0]   byte_i,
  input  logic [1:0]                   size_i,
  input  logic                         full_i,
  input  logic [data_w-1:0]            wdata_i,
  input  logic [way_w-1:0]             rd_way_i,
  output logic [data_w-1:0]            rdata_o
);

  localparam int lanes = data_w / 8;

  logic [data_w-1:0] mem_q [ways][1 << index_w][beats];
  logic [lanes-1:0]  size_lanes;
  logic [lanes-1:0]  wr_lanes;
  logic [lanes-1:0]  rd_lanes;
  logic [5:0]        shamt;
  logic [data_w-1:0] wshift;
  logic [data_w-1:0] rword;
  logic [data_w-1:0] rshift;

  always_comb begin
    size_lanes = '1;
    case (size_i)
      size_b1: size_lanes = lanes'(8'h01);
      size_b2: size_lanes = lanes'(8'h03);
      size_b4: size_lanes = lanes'(8'h0f);
      size_b8: size_lanes = '1;
    endcase
    // full beats bypass lane selection and alignment.
    shamt    = full_i ? 6'd0 : {byte_i, 3'b000};
    wr_lanes = full_i ? '1 : size_lanes << byte_i;
    rd_lanes = full_i ? '1 : size_lanes;
    wshift   = wdata_i << shamt;
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int l = 0; l < lanes; l++) begin
        if (wr_lanes[l]) mem_q[way_i][index_i][beat_i][8*l +: 8] <= wshift[8*l +: 8];
      end
    end
  end

  assign rword  = mem_q[rd_way_i][index_i][beat_i];
  assign rshift = rword >> shamt;

  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      rdata_o[8*l +: 8] = rd_lanes[l] ? rshift[8*l +: 8] : 8'h00;  // zero-extend.
    end
  end

  a_aligned_write: assert property (@(posedge clk)
    we_i && !full_i |-> ((byte_i & ((3'd1 << size_i) - 3'd1)) == 3'd0));

endmodule

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
  parameter int ways = 2,
  localparam int way_w = $clog2(ways)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [addr_w-1:0] req_addr_i,
  input  logic              req_we_i,
  input  logic [1:0]        req_size_i,
  input  logic [data_w-1:0] req_wdata_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [data_w-1:0] rsp_rdata_o,
  output logic              mem_addr_valid_o,
  input  logic              mem_addr_ready_i,
  output logic [addr_w-1:0] mem_addr_o,
  output logic              mem_we_o,
  output logic              mem_wvalid_o,
  input  logic              mem_wready_i,
  output logic [data_w-1:0] mem_wdata_o,
  input  logic              mem_rvalid_i,
  output logic              mem_rready_o,
  input  logic [data_w-1:0] mem_rdata_i,
  input  logic              hit_i,
  input  logic [way_w-1:0]  hit_way_i,
  input  logic [way_w-1:0]  victim_way_i,
  input  logic              victim_dirty_i,
  input  logic [tag_w-1:0]  victim_tag_i,
  input  logic [data_w-1:0] ds_rdata_i,
  output cache_addr_t       lookup_addr_o,
  output logic              set_dirty_o,
  output logic              fill_o,
  output logic [way_w-1:0]  fill_way_o,
  output logic [tag_w-1:0]  fill_tag_o,
  output logic              advance_victim_o,
  output logic              ds_we_o,
  output logic [way_w-1:0]  ds_way_o,
  output logic [beat_w-1:0] ds_beat_o,
  output logic [1:0]        ds_size_o,
  output logic              ds_full_o,
  output logic [data_w-1:0] ds_wdata_o
);

  localparam logic [2:0] st_idle = 3'd0, st_wb_addr = 3'd1, st_wb_data = 3'd2;
  localparam logic [2:0] st_rf_addr = 3'd3, st_rf_data = 3'd4, st_finish = 3'd5;
  localparam logic [2:0] st_respond = 3'd6;

  function automatic cache_addr_t line_of(cache_addr_t a, logic [tag_w-1:0] t);
    cache_addr_t l;
    l.raw     = '0;
    l.f.tag   = t;
    l.f.index = a.f.index;
    return l;
  endfunction

  logic [2:0]        state_q;
  cache_addr_t       req_a, req_q, bus_q, mem_line;
  logic              we_q;
  logic [1:0]        size_q;
  logic [data_w-1:0] wdata_q;
  logic [way_w-1:0]  way_q;
  logic              accept, go_miss, rd_hit, wr_hit;
  logic              aw_fire, w_fire, r_fire, last_beat;

  assign req_a     = req_addr_i;
  assign accept    = req_valid_i && req_ready_o;  // ready is only high in idle.
  assign go_miss   = accept && !hit_i;
  assign rd_hit    = accept && hit_i && !req_we_i;
  assign wr_hit    = accept && hit_i && req_we_i;
  assign aw_fire   = mem_addr_valid_o && mem_addr_ready_i;
  assign w_fire    = mem_wvalid_o && mem_wready_i;
  assign r_fire    = mem_rvalid_i && mem_rready_o;
  assign last_beat = bus_q.f.beat == beat_w'(beats - 1);

  assign mem_line    = line_of(bus_q, bus_q.f.tag);
  assign mem_addr_o  = mem_line.raw;
  assign mem_wdata_o = ds_rdata_i;

  // store updates.
  assign set_dirty_o      = wr_hit || (state_q == st_finish && we_q);
  assign ds_we_o          = set_dirty_o || r_fire;
  assign fill_o           = r_fire && last_beat;
  assign fill_way_o       = way_q;
  assign fill_tag_o       = req_q.f.tag;
  assign advance_victim_o = go_miss;

  always_comb begin
    lookup_addr_o = req_q;
    ds_way_o      = way_q;
    ds_beat_o     = req_q.f.beat;
    ds_size_o     = size_q;
    ds_full_o     = 1'b0;
    ds_wdata_o    = wdata_q;
    case (state_q)
      st_idle: begin
        lookup_addr_o = req_a;
        ds_way_o      = hit_way_i;
        ds_beat_o     = req_a.f.beat;
        ds_size_o     = req_size_i;
        ds_wdata_o    = req_wdata_i;
      end
      st_wb_addr, st_wb_data, st_rf_addr: begin
        ds_full_o = 1'b1;
        ds_beat_o = bus_q.f.beat;
      end
      st_rf_data: begin
        ds_full_o  = 1'b1;
        ds_beat_o  = bus_q.f.beat;
        ds_wdata_o = mem_rdata_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= st_idle;
      req_ready_o      <= 1'b1;
      rsp_valid_o      <= 1'b0;
      mem_addr_valid_o <= 1'b0;
      mem_wvalid_o     <= 1'b0;
      mem_rready_o     <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (go_miss) begin
            req_ready_o      <= 1'b0;
            mem_addr_valid_o <= 1'b1;
            state_q          <= victim_dirty_i ? st_wb_addr : st_rf_addr;
          end else if (rd_hit) begin
            req_ready_o <= 1'b0;
            rsp_valid_o <= 1'b1;
            state_q     <= st_respond;
          end
        end
        st_wb_addr: if (aw_fire) begin
          mem_addr_valid_o <= 1'b0;
          mem_wvalid_o     <= 1'b1;
          state_q          <= st_wb_data;
        end
        st_wb_data: if (w_fire && last_beat) begin
          mem_wvalid_o     <= 1'b0;
          mem_addr_valid_o <= 1'b1;
          state_q          <= st_rf_addr;
        end
        st_rf_addr: if (aw_fire) begin
          mem_addr_valid_o <= 1'b0;
          mem_rready_o     <= 1'b1;
          state_q          <= st_rf_data;
        end
        st_rf_data: if (r_fire && last_beat) begin
          mem_rready_o <= 1'b0;
          state_q      <= st_finish;
        end
        st_finish: begin
          if (we_q) begin
            req_ready_o <= 1'b1;
            state_q     <= st_idle;
          end else begin
            rsp_valid_o <= 1'b1;
            state_q     <= st_respond;
          end
        end
        st_respond: if (rsp_ready_i) begin
          rsp_valid_o <= 1'b0;
          req_ready_o <= 1'b1;
          state_q     <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (go_miss) begin
      req_q    <= req_a;
      we_q     <= req_we_i;
      size_q   <= req_size_i;
      wdata_q  <= req_wdata_i;
      way_q    <= victim_way_i;
      mem_we_o <= victim_dirty_i;
      bus_q    <= line_of(req_a, victim_dirty_i ? victim_tag_i : req_a.f.tag);
    end
    if (rd_hit || (state_q == st_finish && !we_q)) rsp_rdata_o <= ds_rdata_i;
    if (w_fire || r_fire) bus_q.raw <= bus_q.raw + addr_w'(data_w / 8);
    if (w_fire && last_beat) begin
      bus_q    <= line_of(req_q, req_q.f.tag);  // on to the refill.
      mem_we_o <= 1'b0;
    end
  end

  a_addr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_addr_valid_o && !mem_addr_ready_i |=> mem_addr_valid_o);

  a_ready_idle: assert property (@(posedge clk) disable iff (rst)
    (state_q != st_idle) |-> !req_ready_o);

endmodule

// File: hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
  parameter int ways = 2,
  localparam int way_w = $clog2(ways)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [addr_w-1:0] req_addr_i,
  input  logic              req_we_i,
  input  logic [1:0]        req_size_i,
  input  logic [data_w-1:0] req_wdata_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [data_w-1:0] rsp_rdata_o,
  output logic              mem_addr_valid_o,
  input  logic              mem_addr_ready_i,
  output logic [addr_w-1:0] mem_addr_o,
  output logic              mem_we_o,
  output logic              mem_wvalid_o,
  input  logic              mem_wready_i,
  output logic [data_w-1:0] mem_wdata_o,
  input  logic              mem_rvalid_i,
  output logic              mem_rready_o,
  input  logic [data_w-1:0] mem_rdata_i
);

  cache_addr_t       lookup_addr;
  logic              hit;
  logic [way_w-1:0]  hit_way;
  logic [way_w-1:0]  victim_way;
  logic              victim_dirty;
  logic [tag_w-1:0]  victim_tag;
  logic              set_dirty;
  logic              fill;
  logic [way_w-1:0]  fill_way;
  logic [tag_w-1:0]  fill_tag;
  logic              advance_victim;
  logic              ds_we;
  logic [way_w-1:0]  ds_way;
  logic [beat_w-1:0] ds_beat;
  logic [1:0]        ds_size;
  logic              ds_full;
  logic [data_w-1:0] ds_wdata;
  logic [data_w-1:0] ds_rdata;

  tag_store #(.ways(ways)) u_tags (
    .clk(clk), .rst(rst),
    .lookup_addr_i(lookup_addr),
    .set_dirty_i(set_dirty),
    .fill_i(fill),
    .fill_way_i(fill_way),
    .fill_index_i(lookup_addr.f.index),  // refill always targets the pending request set.
    .fill_tag_i(fill_tag),
    .advance_victim_i(advance_victim),
    .hit_o(hit), .hit_way_o(hit_way),
    .victim_way_o(victim_way), .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
  );

  data_store #(.ways(ways)) u_data (
    .clk(clk),
    .we_i(ds_we), .way_i(ds_way),
    .index_i(lookup_addr.f.index), .beat_i(ds_beat), .byte_i(lookup_addr.f.byte_off),
    .size_i(ds_size), .full_i(ds_full), .wdata_i(ds_wdata),
    .rd_way_i(ds_way),
    .rdata_o(ds_rdata)
  );

  cache_ctrl #(.ways(ways)) u_ctrl (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_addr_i(req_addr_i),
    .req_we_i(req_we_i), .req_size_i(req_size_i), .req_wdata_i(req_wdata_i),
    .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_rdata_o(rsp_rdata_o),
    .mem_addr_valid_o(mem_addr_valid_o), .mem_addr_ready_i(mem_addr_ready_i),
    .mem_addr_o(mem_addr_o), .mem_we_o(mem_we_o),
    .mem_wvalid_o(mem_wvalid_o), .mem_wready_i(mem_wready_i), .mem_wdata_o(mem_wdata_o),
    .mem_rvalid_i(mem_rvalid_i), .mem_rready_o(mem_rready_o), .mem_rdata_i(mem_rdata_i),
    .hit_i(hit), .hit_way_i(hit_way),
    .victim_way_i(victim_way), .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
    .ds_rdata_i(ds_rdata),
    .lookup_addr_o(lookup_addr), .set_dirty_o(set_dirty),
    .fill_o(fill), .fill_way_o(fill_way), .fill_tag_o(fill_tag),
    .advance_victim_o(advance_victim),
    .ds_we_o(ds_we), .ds_way_o(ds_way), .ds_beat_o(ds_beat), .ds_size_o(ds_size),
    .ds_full_o(ds_full), .ds_wdata_o(ds_wdata)
  );

endmodule

// File: verif/mem_model.sv
`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall_i,
  input  logic              addr_valid_i,
  output logic              addr_ready_o,
  input  logic [addr_w-1:0] addr_i,
  input  logic              we_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  input  logic [data_w-1:0] wdata_i,
  output logic              rvalid_o,
  input  logic              rready_i,
  output logic [data_w-1:0] rdata_o,
  input  logic [addr_w-1:0] peek_addr_i,
  output logic [data_w-1:0] peek_data_o,
  output int                aw_count_o
);

  logic [7:0]        mem [logic [addr_w-1:0]];  // only bytes written back.
  logic              busy;
  logic              wr;
  logic [addr_w-1:0] base;
  int                beat;

  // fill pattern, same formula as the testbench shadow.
  function automatic logic [7:0] init_byte(logic [addr_w-1:0] a);
    return 8'((a * 32'h9e3779b1) >> 24);
  endfunction

  function automatic logic [data_w-1:0] word_at(logic [addr_w-1:0] a);
    logic [data_w-1:0] w;
    logic [addr_w-1:0] b;
    for (int i = 0; i < data_w / 8; i++) begin
      b = a + addr_w'(i);
      w[8*i +: 8] = mem.exists(b) ? mem[b] : init_byte(b);
    end
    return w;
  endfunction

  // one in four cycles stalls when enabled.
  function automatic logic go();
    return !stall_i || (($urandom % 4) != 0);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      busy         <= 1'b0;
      addr_ready_o <= 1'b0;
      wready_o     <= 1'b0;
      rvalid_o     <= 1'b0;
      aw_count_o   <= 0;
      beat         <= 0;
    end else if (!busy) begin
      addr_ready_o <= go();
      if (addr_valid_i && addr_ready_o) begin
        busy         <= 1'b1;
        wr           <= we_i;
        base         <= addr_i;
        beat         <= 0;
        addr_ready_o <= 1'b0;
        aw_count_o   <= aw_count_o + 1;
      end
    end else if (wr) begin
      wready_o <= go();
      if (wvalid_i && wready_o) begin
        for (int i = 0; i < data_w / 8; i++) begin
          mem[base + addr_w'(8 * beat + i)] = wdata_i[8*i +: 8];
        end
        beat <= beat + 1;
        if (beat == beats - 1) begin
          busy     <= 1'b0;
          wready_o <= 1'b0;
        end
      end
    end else begin
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        beat     <= beat + 1;
        if (beat == beats - 1) busy <= 1'b0;  // burst done.
      end else if (!rvalid_o && go()) begin
        rvalid_o <= 1'b1;
        rdata_o  <= word_at(base + addr_w'(8 * beat));
      end
    end
    peek_data_o <= word_at(peek_addr_i);
  end

endmodule

// File: verif/cache_tb.sv
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  localparam int limit = 2000;  // cycles allowed for any one wait.

  logic              clk = 1'b0;
  logic              rst;
  logic              hung = 1'b0;
  logic              req_valid;
  logic              req_ready;
  logic [addr_w-1:0] req_addr;
  logic              req_we;
  logic [1:0]        req_size;
  logic [data_w-1:0] req_wdata;
  logic              rsp_valid;
  logic              rsp_ready;
  logic [data_w-1:0] rsp_rdata;
  logic              mem_addr_valid;
  logic              mem_addr_ready;
  logic [addr_w-1:0] mem_addr;
  logic              mem_we;
  logic              mem_wvalid;
  logic              mem_wready;
  logic [data_w-1:0] mem_wdata;
  logic              mem_rvalid;
  logic              mem_rready;
  logic [data_w-1:0] mem_rdata;
  logic              stall;
  logic [addr_w-1:0] peek_addr;
  logic [data_w-1:0] peek_data;
  int                aw_count;
  logic [7:0]        shadow [logic [addr_w-1:0]];
  logic [addr_w-1:0] wb_lines [$];
  int                errors = 0;
  int                tests = 0;

  cache_top #(.ways(2)) DUT (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_addr_i(req_addr),
    .req_we_i(req_we), .req_size_i(req_size), .req_wdata_i(req_wdata),
    .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_rdata_o(rsp_rdata),
    .mem_addr_valid_o(mem_addr_valid), .mem_addr_ready_i(mem_addr_ready),
    .mem_addr_o(mem_addr), .mem_we_o(mem_we),
    .mem_wvalid_o(mem_wvalid), .mem_wready_i(mem_wready), .mem_wdata_o(mem_wdata),
    .mem_rvalid_i(mem_rvalid), .mem_rready_o(mem_rready), .mem_rdata_i(mem_rdata)
  );

  mem_model u_mem (
    .clk(clk), .rst(rst), .stall_i(stall),
    .addr_valid_i(mem_addr_valid), .addr_ready_o(mem_addr_ready), .addr_i(mem_addr),
    .we_i(mem_we), .wvalid_i(mem_wvalid), .wready_o(mem_wready), .wdata_i(mem_wdata),
    .rvalid_o(mem_rvalid), .rready_i(mem_rready), .rdata_o(mem_rdata),
    .peek_addr_i(peek_addr), .peek_data_o(peek_data), .aw_count_o(aw_count)
  );

  always #50 clk = ~clk;

  // lines the cache writes back.
  always @(posedge clk) begin
    if (mem_addr_valid && mem_addr_ready && mem_we) wb_lines.push_back(mem_addr);
  end

  initial begin
    wait (hung);
    $display("summary: %0d tests run, %0d errors", tests, errors);
    $display("Verification failed");
    $finish;
  end

  function automatic logic [7:0] init_byte(logic [addr_w-1:0] a);
    return 8'((a * 32'h9e3779b1) >> 24);
  endfunction

  function automatic logic [data_w-1:0] expect_read(logic [addr_w-1:0] a, logic [1:0] size);
    logic [data_w-1:0] v;
    logic [addr_w-1:0] b;
    v = '0;
    for (int i = 0; i < (1 << size); i++) begin
      b = a + addr_w'(i);
      v[8*i +: 8] = shadow.exists(b) ? shadow[b] : init_byte(b);
    end
    return v;  // little endian, zero-extended.
  endfunction

  task automatic value_error(string sig, logic [data_w-1:0] got, logic [data_w-1:0] exp);
    $display("error at time %0t: %s is %h, expected %h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic give_up(string what);
    $display("timeout at time %0t: no progress while waiting for %s", $time, what);
    hung = 1'b1;
    forever @(posedge clk);
  endtask

  task automatic end_test(string name, int errs_at_start);
    tests++;
    if (errors == errs_at_start) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - errs_at_start);
  endtask

  task automatic send_req(logic [addr_w-1:0] a, logic we, logic [1:0] size,
                          logic [data_w-1:0] wd);
    int n;
    req_valid <= 1'b1;
    req_addr  <= a;
    req_we    <= we;
    req_size  <= size;
    req_wdata <= wd;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > limit) give_up("req_ready_o to accept a request");
    end while (!req_ready);
    req_valid <= 1'b0;
  endtask

  task automatic write_req(logic [addr_w-1:0] a, logic [1:0] size, logic [data_w-1:0] wd);
    int n;
    send_req(a, 1'b1, size, wd);
    for (int i = 0; i < (1 << size); i++) shadow[a + addr_w'(i)] = wd[8*i +: 8];
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > limit) give_up("req_ready_o after a write");
    end while (!req_ready);  // a write miss ends here.
  endtask

  task automatic read_check(logic [addr_w-1:0] a, logic [1:0] size);
    logic [data_w-1:0] exp;
    logic [data_w-1:0] held;
    bit                seen;
    bit                done;
    int                n;
    exp  = expect_read(a, size);
    seen = 1'b0;
    n    = 0;
    send_req(a, 1'b0, size, '0);
    do begin
      @(posedge clk);
      n++;
      if (n > limit) give_up("rsp_valid_o");
      if (rsp_valid && seen && rsp_rdata !== held) begin
        value_error("rsp_rdata_o held", rsp_rdata, held);
      end
      if (rsp_valid && !seen) begin
        held = rsp_rdata;
        seen = 1'b1;
      end
      done = rsp_valid && rsp_ready;
      if (stall) rsp_ready <= ($urandom % 3) != 0;
    end while (!done);
    if (rsp_rdata !== exp) value_error($sformatf("rsp_rdata_o for %h", a), rsp_rdata, exp);
  endtask

  task automatic check_line(logic [addr_w-1:0] line);
    logic [addr_w-1:0] wa;
    for (int b = 0; b < beats; b++) begin
      wa = line + addr_w'(8 * b);
      peek_addr <= wa;
      repeat (2) @(posedge clk);  // peek port is registered.
      if (peek_data !== expect_read(wa, size_b8)) begin
        value_error($sformatf("backing memory at %h", wa), peek_data, expect_read(wa, size_b8));
      end
    end
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    if (req_ready !== 1'b1) value_error("req_ready_o", 64'(req_ready), 64'd1);
    if (rsp_valid !== 1'b0) value_error("rsp_valid_o", 64'(rsp_valid), 64'd0);
    if (mem_addr_valid !== 1'b0) value_error("mem_addr_valid_o", 64'(mem_addr_valid), 64'd0);
    if (mem_wvalid !== 1'b0) value_error("mem_wvalid_o", 64'(mem_wvalid), 64'd0);
    if (mem_rready !== 1'b0) value_error("mem_rready_o", 64'(mem_rready), 64'd0);
    end_test("reset", e0);
  endtask

  task automatic miss_then_hit();
    int e0;
    int count;
    e0 = errors;
    read_check(32'h0000_4010, size_b8);
    count = aw_count;
    read_check(32'h0000_4010, size_b8);
    if (aw_count != count) value_error("aw_count_o", 64'(aw_count), 64'(count));
    end_test("read miss then hit", e0);
  endtask

  task automatic sized_writes();
    int e0;
    e0 = errors;
    write_req(32'h0000_2080, size_b8, {$urandom, $urandom});
    write_req(32'h0000_2084, size_b4, {$urandom, $urandom});
    write_req(32'h0000_2082, size_b2, {$urandom, $urandom});
    write_req(32'h0000_2081, size_b1, {$urandom, $urandom});
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) read_check(32'h0000_2080 + off, 2'(s));
    end
    end_test("sized writes", e0);
  endtask

  task automatic dirty_eviction();
    logic [addr_w-1:0] a [3];
    int                e0;
    e0 = errors;
    wb_lines.delete();
    a = '{32'h0000_0140, 32'h0000_0948, 32'h0000_1150};  // three tags in set 5.
    foreach (a[i]) write_req(a[i], size_b8, {$urandom, $urandom});
    foreach (a[i]) read_check(a[i], size_b8);
    if (wb_lines.size() == 0) begin
      $display("no dirty line was written back during the eviction test");
      errors++;
    end
    foreach (wb_lines[i]) check_line(wb_lines[i]);
    end_test("dirty eviction", e0);
  endtask

  task automatic back_pressure();
    logic [addr_w-1:0] a;
    logic [1:0]        sz;
    int                e0;
    e0 = errors;
    stall <= 1'b1;
    for (int i = 0; i < 40; i++) begin
      sz = 2'($urandom % 4);
      a  = (32'h1000_0000 | ($urandom & 32'h0000_3fff)) & ~((32'd1 << sz) - 32'd1);
      if (($urandom % 3) == 0) write_req(a, sz, {$urandom, $urandom});
      else read_check(a, sz);
    end
    stall     <= 1'b0;
    rsp_ready <= 1'b1;
    end_test("back-pressure", e0);
  endtask

  initial begin
    void'($urandom(32'h38c7a602));
    rst       = 1'b1;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_size  = size_b1;
    req_wdata = '0;
    rsp_ready = 1'b1;
    stall     = 1'b0;
    peek_addr = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    reset_state();
    miss_then_hit();
    sized_writes();
    dirty_eviction();
    back_pressure();
    $display("summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

endmodule

// File: compile.f
hdl/cache_pkg.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
verif/mem_model.sv
verif/cache_tb.sv

// File: Makefile
TOP       ?= cache_tb
FILELIST  ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o sim
	@./$(BUILD)/sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	  if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	  fi

clean:
	rm -rf $(BUILD) $(LOG)
